// ==== design/kyber_pkg.sv ====
// Kyber v-noise stage shared constants and data widths
`default_nettype none

package kyber_pkg;

  // One coefficient in the range 0 to q-1
  typedef logic [11:0] coef_t;

  // One input byte of randomness or message
  typedef logic [7:0] byte_t;

  // Position of a coefficient inside a polynomial
  typedef logic [7:0] coef_index_t;

  // Kyber modulus
  localparam coef_t kyber_q = 12'd3329;

  // Decompress1 of a set bit, (q+1)/2
  localparam coef_t kyber_half_q = 12'd1665;

  // Coefficients per polynomial
  localparam int kyber_n = 256;

endpackage : kyber_pkg

`default_nettype wire

// ==== design/cbd_sampler.sv ====
// CBD sampler converting randomness bytes into eta-2 noise coefficients under credit control
`timescale 1ns/1ps
`default_nettype none

module cbd_sampler #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            noise_valid,
  input  kyber_pkg::byte_t noise_byte,
  input  logic            credit_return,
  output logic            noise_ready,
  output logic            push,
  output kyber_pkg::coef_t push_coef
);

  import kyber_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  typedef enum logic {
    first_half,
    second_half
  } half_t;

  half_t            half;
  byte_t            byte_q;
  logic             byte_held;
  logic [CNT_W-1:0] credit_cnt;
  logic             accept;
  logic [3:0]       nibble;
  logic [1:0]       pos_cnt;
  logic [1:0]       neg_cnt;

  assign noise_ready = !byte_held;
  assign accept      = noise_valid && noise_ready;

  // A held byte goes out one coefficient per credited cycle
  assign push = byte_held && (credit_cnt != '0);

  // Centered binomial over the selected nibble
  always_comb begin
    nibble  = (half == first_half) ? byte_q[3:0] : byte_q[7:4];
    pos_cnt = {1'b0, nibble[0]} + {1'b0, nibble[1]};
    neg_cnt = {1'b0, nibble[2]} + {1'b0, nibble[3]};
    if (pos_cnt >= neg_cnt) begin
      push_coef = coef_t'(pos_cnt - neg_cnt);
    end else begin
      // Negative values wrap to q + x
      push_coef = kyber_q - coef_t'(neg_cnt - pos_cnt);
    end
  end

  // Accepted randomness byte
  always_ff @(posedge clk) begin
    if (accept) begin
      byte_q <= noise_byte;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      byte_held <= 1'b0;
      half      <= first_half;
    end else if (accept) begin
      byte_held <= 1'b1;
      half      <= first_half;
    end else if (push) begin
      if (half == first_half) begin
        half <= second_half;
      end else begin
        // Second coefficient sent so the next byte may enter
        half      <= first_half;
        byte_held <= 1'b0;
      end
    end
  end

  // Credits start full and move by one per push and per returned credit
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      credit_cnt <= CNT_W'(FIFO_DEPTH);
    end else begin
      case ({push, credit_return})
        2'b10: credit_cnt <= credit_cnt - 1'b1;
        2'b01: credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule : cbd_sampler

`default_nettype wire

// ==== design/noise_fifo.sv ====
// Noise FIFO holding sampled coefficients in show-ahead order and returning credits on pop
`timescale 1ns/1ps
`default_nettype none

module noise_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  kyber_pkg::coef_t push_coef,
  input  logic             pop,
  output kyber_pkg::coef_t fifo_coef,
  output logic             fifo_nonempty,
  output logic             credit_return
);

  import kyber_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  coef_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Head entry shown without delay
  assign fifo_coef     = mem[rd_ptr];
  assign fifo_nonempty = (count != '0);

  // Every pop frees one slot at the sender
  assign credit_return = pop;

  // Storage array, no full check since the sender holds credits
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_coef;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        if (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // Occupancy holds when push and pop coincide
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule : noise_fifo

`default_nettype wire

// ==== design/message_adder.sv ====
// Message adder forming v = e2 + Decompress1(m) with indexed, back-pressured output
`timescale 1ns/1ps
`default_nettype none

module message_adder (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     msg_valid,
  input  kyber_pkg::byte_t         msg_byte,
  input  kyber_pkg::coef_t         fifo_coef,
  input  logic                     fifo_nonempty,
  input  logic                     coef_ready,
  output logic                     msg_ready,
  output logic                     pop,
  output logic                     coef_valid,
  output kyber_pkg::coef_t         coef,
  output kyber_pkg::coef_index_t   coef_index,
  output logic                     done
);

  import kyber_pkg::*;

  byte_t       msg_bits;
  logic [3:0]  bits_left;
  logic        msg_accept;
  logic        out_free;
  logic        load;
  logic        transfer;
  logic [12:0] sum_raw;
  coef_t       sum_mod;

  // New byte only once every bit of the last one is used
  assign msg_ready  = (bits_left == 4'd0);
  assign msg_accept = msg_valid && msg_ready;

  // Output slot is free when empty or being taken this cycle
  assign out_free = !coef_valid || coef_ready;
  assign load     = out_free && (bits_left != 4'd0) && fifo_nonempty;
  assign pop      = load;
  assign transfer = coef_valid && coef_ready;

  // Decompress1 of the current bit, then one conditional subtraction of q
  always_comb begin
    sum_raw = {1'b0, fifo_coef};
    if (msg_bits[0]) begin
      sum_raw = sum_raw + {1'b0, kyber_half_q};
    end
    if (sum_raw >= {1'b0, kyber_q}) begin
      sum_mod = coef_t'(sum_raw - {1'b0, kyber_q});
    end else begin
      sum_mod = coef_t'(sum_raw);
    end
  end

  // Last coefficient of the polynomial leaves with done
  assign done = transfer && (coef_index == coef_index_t'(kyber_n - 1));

  // Message bits leave LSB first
  always_ff @(posedge clk) begin
    if (msg_accept) begin
      msg_bits <= msg_byte;
    end else if (load) begin
      msg_bits <= {1'b0, msg_bits[7:1]};
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      bits_left <= 4'd0;
    end else if (msg_accept) begin
      bits_left <= 4'd8;
    end else if (load) begin
      bits_left <= bits_left - 4'd1;
    end
  end

  // Result register, held while the sink stalls
  always_ff @(posedge clk) begin
    if (load) begin
      coef <= sum_mod;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      coef_valid <= 1'b0;
    end else if (load) begin
      coef_valid <= 1'b1;
    end else if (coef_ready) begin
      coef_valid <= 1'b0;
    end
  end

  // Index counts transfers, 8 bits wrap at the polynomial end
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      coef_index <= '0;
    end else if (transfer) begin
      coef_index <= coef_index + 1'b1;
    end
  end

endmodule : message_adder

`default_nettype wire

// ==== design/kyber_v_noise.sv ====
// Kyber v-noise top connecting CBD sampler, noise FIFO and message adder
`timescale 1ns/1ps
`default_nettype none

module kyber_v_noise #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   noise_valid,
  input  kyber_pkg::byte_t       noise_byte,
  input  logic                   msg_valid,
  input  kyber_pkg::byte_t       msg_byte,
  input  logic                   coef_ready,
  output logic                   noise_ready,
  output logic                   msg_ready,
  output logic                   coef_valid,
  output kyber_pkg::coef_t       coef,
  output kyber_pkg::coef_index_t coef_index,
  output logic                   done
);

  import kyber_pkg::*;

  // Sampler to FIFO, credit based
  logic  push;
  coef_t push_coef;
  logic  credit_return;

  // FIFO to adder, show-ahead
  coef_t fifo_coef;
  logic  fifo_nonempty;
  logic  pop;

  cbd_sampler #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_cbd_sampler (
    .clk           (clk),
    .reset         (reset),
    .noise_valid   (noise_valid),
    .noise_byte    (noise_byte),
    .credit_return (credit_return),
    .noise_ready   (noise_ready),
    .push          (push),
    .push_coef     (push_coef)
  );

  noise_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_noise_fifo (
    .clk           (clk),
    .reset         (reset),
    .push          (push),
    .push_coef     (push_coef),
    .pop           (pop),
    .fifo_coef     (fifo_coef),
    .fifo_nonempty (fifo_nonempty),
    .credit_return (credit_return)
  );

  message_adder u_message_adder (
    .clk           (clk),
    .reset         (reset),
    .msg_valid     (msg_valid),
    .msg_byte      (msg_byte),
    .fifo_coef     (fifo_coef),
    .fifo_nonempty (fifo_nonempty),
    .coef_ready    (coef_ready),
    .msg_ready     (msg_ready),
    .pop           (pop),
    .coef_valid    (coef_valid),
    .coef          (coef),
    .coef_index    (coef_index),
    .done          (done)
  );

endmodule : kyber_v_noise

`default_nettype wire

// ==== test/kyber_v_noise_sva.sv ====
// Handshake and credit assertions for the Kyber v-noise stage
`timescale 1ns/1ps
`default_nettype none

module kyber_v_noise_sva #(
  parameter int FIFO_DEPTH = 4
) (
  input logic                   clk,
  input logic                   reset,
  input logic                   push,
  input logic                   credit_return,
  input logic                   pop,
  input logic                   fifo_nonempty,
  input logic                   coef_valid,
  input logic                   coef_ready,
  input kyber_pkg::coef_t       coef,
  input kyber_pkg::coef_index_t coef_index,
  input logic                   done
);

  int         credits;
  logic [7:0] xfer_cnt;
  int         fail_count = 0;

  // Mirror of the sampler credit counter
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      credits <= FIFO_DEPTH;
    end else begin
      credits <= credits - int'(push) + int'(credit_return);
    end
  end

  // Output transfers since reset, counted modulo one polynomial
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      xfer_cnt <= '0;
    end else if (coef_valid && coef_ready) begin
      xfer_cnt <= xfer_cnt + 1'b1;
    end
  end

  credit_range: assert property (@(posedge clk) disable iff (reset)
    credits >= 0 && credits <= FIFO_DEPTH)
    else begin
      $error("credit count out of range");
      fail_count++;
    end

  // Spent credits equal the entries pushed and not yet popped
  pop_needs_data: assert property (@(posedge clk) disable iff (reset)
    pop |-> (fifo_nonempty && credits < FIFO_DEPTH))
    else begin
      $error("pop from an empty FIFO");
      fail_count++;
    end

  // Output held under back-pressure
  output_hold: assert property (@(posedge clk) disable iff (reset)
    (coef_valid && !coef_ready) |=> (coef_valid && $stable(coef) && $stable(coef_index)))
    else begin
      $error("output changed while stalled");
      fail_count++;
    end

  // Done marks exactly the last transfer of every polynomial
  done_at_last: assert property (@(posedge clk) disable iff (reset)
    done == (coef_valid && coef_ready && xfer_cnt == 8'd255))
    else begin
      $error("done without transfer of the last index");
      fail_count++;
    end

endmodule : kyber_v_noise_sva

bind kyber_v_noise kyber_v_noise_sva #(
  .FIFO_DEPTH (FIFO_DEPTH)
) u_kyber_v_noise_sva (
  .clk           (clk),
  .reset         (reset),
  .push          (push),
  .credit_return (credit_return),
  .pop           (pop),
  .fifo_nonempty (fifo_nonempty),
  .coef_valid    (coef_valid),
  .coef_ready    (coef_ready),
  .coef          (coef),
  .coef_index    (coef_index),
  .done          (done)
);

`default_nettype wire

// ==== test/tb_kyber_v_noise.sv ====
// Table-driven testbench for the Kyber v-noise stage with noise, message and output streams
`timescale 1ns/1ps
`default_nettype none

module tb_kyber_v_noise;

  import kyber_pkg::*;

  localparam int num_entries    = 4;
  localparam int noise_per_poly = kyber_n / 2;
  localparam int msg_per_poly   = kyber_n / 8;
  localparam int total_coefs    = num_entries * kyber_n;
  localparam int timeout_cycles = num_entries * kyber_n * 12 + 2000;

  localparam logic [1:0] noise_zero = 2'd0;
  localparam logic [1:0] noise_ones = 2'd1;
  localparam logic [1:0] noise_alt  = 2'd2;
  localparam logic [1:0] noise_rand = 2'd3;
  localparam logic       msg_zero   = 1'b0;
  localparam logic       msg_rand   = 1'b1;

  // One polynomial per entry with input gap and output stall percentages
  typedef struct packed {
    logic [1:0] noise_pat;
    logic       msg_pat;
    logic [7:0] gap_pct;
    logic [7:0] stall_pct;
  } entry_t;

  entry_t test_table [num_entries] = '{
    '{noise_zero, msg_zero, 8'd0,  8'd0},
    '{noise_ones, msg_zero, 8'd30, 8'd0},
    '{noise_alt,  msg_zero, 8'd0,  8'd40},
    '{noise_rand, msg_rand, 8'd25, 8'd30}
  };

  logic        clk = 1'b0;
  logic        reset;
  logic        noise_valid;
  byte_t       noise_byte;
  logic        msg_valid;
  byte_t       msg_byte;
  logic        coef_ready;
  logic        noise_ready;
  logic        msg_ready;
  logic        coef_valid;
  coef_t       coef;
  coef_index_t coef_index;
  logic        done;

  byte_t noise_bytes [num_entries * noise_per_poly];
  byte_t msg_bytes [num_entries * msg_per_poly];
  coef_t exp_q [$];

  int errors      = 0;
  int out_count   = 0;
  int done_count  = 0;
  int noise_taken = 0;
  int msg_taken   = 0;
  int cycle_count = 0;
  bit timed_out   = 1'b0;

  kyber_v_noise #(
    .FIFO_DEPTH (4)
  ) u_kyber_v_noise (
    .clk         (clk),
    .reset       (reset),
    .noise_valid (noise_valid),
    .noise_byte  (noise_byte),
    .msg_valid   (msg_valid),
    .msg_byte    (msg_byte),
    .coef_ready  (coef_ready),
    .noise_ready (noise_ready),
    .msg_ready   (msg_ready),
    .coef_valid  (coef_valid),
    .coef        (coef),
    .coef_index  (coef_index),
    .done        (done)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  // Eta-2 binomial value of a nibble with negatives mapped to q + x
  function automatic int cbd_value(input logic [3:0] nib);
    int v;
    v = int'(nib[0]) + int'(nib[1]) - int'(nib[2]) - int'(nib[3]);
    if (v < 0) begin
      v = int'(kyber_q) + v;
    end
    return v;
  endfunction

  task automatic build_stimulus;
    int    e;
    int    i;
    int    k;
    int    bit_val;
    byte_t b;
    for (e = 0; e < num_entries; e++) begin
      for (i = 0; i < noise_per_poly; i++) begin
        case (test_table[e].noise_pat)
          noise_zero: b = 8'h00;
          noise_ones: b = 8'hFF;
          noise_alt:  b = (i % 2 == 0) ? 8'h33 : 8'hCC;
          default:    b = byte_t'($urandom);
        endcase
        noise_bytes[e * noise_per_poly + i] = b;
      end
      for (i = 0; i < msg_per_poly; i++) begin
        msg_bytes[e * msg_per_poly + i] =
          (test_table[e].msg_pat == msg_zero) ? 8'h00 : byte_t'($urandom);
      end
    end
    // Coefficient k uses noise nibble k and message bit k, LSB first
    for (k = 0; k < total_coefs; k++) begin
      b = noise_bytes[k / 2];
      bit_val = int'(msg_bytes[k / 8][k % 8]);
      exp_q.push_back(coef_t'((cbd_value((k % 2 == 0) ? b[3:0] : b[7:4])
                               + bit_val * int'(kyber_half_q)) % int'(kyber_q)));
    end
  endtask

  task automatic drive_noise;
    int i;
    bit taken;
    for (i = 0; i < num_entries * noise_per_poly; i++) begin
      while (($urandom % 100) < test_table[i / noise_per_poly].gap_pct) begin
        noise_valid = 1'b0;
        @(posedge clk);
        #2;
      end
      noise_valid = 1'b1;
      noise_byte  = noise_bytes[i];
      taken       = 1'b0;
      while (!taken) begin
        @(negedge clk);
        taken = noise_ready;
        @(posedge clk);
        #2;
      end
      noise_taken++;
    end
    noise_valid = 1'b0;
  endtask

  task automatic drive_message;
    int i;
    bit taken;
    for (i = 0; i < num_entries * msg_per_poly; i++) begin
      while (($urandom % 100) < test_table[i / msg_per_poly].gap_pct) begin
        msg_valid = 1'b0;
        @(posedge clk);
        #2;
      end
      msg_valid = 1'b1;
      msg_byte  = msg_bytes[i];
      taken     = 1'b0;
      while (!taken) begin
        @(negedge clk);
        taken = msg_ready;
        @(posedge clk);
        #2;
      end
      msg_taken++;
    end
    msg_valid = 1'b0;
  endtask

  task automatic drive_ready;
    int e;
    forever begin
      e = out_count / kyber_n;
      if (e >= num_entries) begin
        e = num_entries - 1;
      end
      coef_ready = (($urandom % 100) >= test_table[e].stall_pct);
      @(posedge clk);
      #2;
    end
  endtask

  // Sampled mid-cycle since a transfer completes at the next rising edge
  task automatic monitor_output;
    coef_t       held_coef;
    coef_index_t held_index;
    bit          stalled;
    bit          transfer;
    stalled = 1'b0;
    while (out_count < total_coefs) begin
      @(negedge clk);
      if (stalled) begin
        check_value("coef_valid", coef_valid, 1);
        check_value("coef", coef, held_coef);
        check_value("coef_index", coef_index, held_index);
      end
      stalled    = coef_valid && !coef_ready;
      held_coef  = coef;
      held_index = coef_index;
      transfer   = coef_valid && coef_ready;
      check_value("done", done, transfer && (out_count % kyber_n == kyber_n - 1));
      if (transfer) begin
        check_value("coef", coef, exp_q.pop_front());
        check_value("coef_index", coef_index, out_count % kyber_n);
        if (done) begin
          done_count++;
        end
        out_count++;
      end
    end
  endtask

  task automatic finish_run;
    $display("errors %0d, assertion failures %0d, outputs %0d, timeout %0d",
             errors, u_kyber_v_noise.u_kyber_v_noise_sva.fail_count, out_count, timed_out);
    if (errors == 0 && u_kyber_v_noise.u_kyber_v_noise_sva.fail_count == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  initial begin : watchdog
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
    end
    $display("timeout: output stream did not complete");
    timed_out = 1'b1;
    finish_run();
  end

  initial begin
    void'($urandom(73270));
    reset       = 1'b1;
    noise_valid = 1'b0;
    noise_byte  = '0;
    msg_valid   = 1'b0;
    msg_byte    = '0;
    coef_ready  = 1'b0;
    build_stimulus();
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    fork
      drive_noise();
      drive_message();
      drive_ready();
    join_none
    monitor_output();
    // Every byte taken once and the pipeline drained
    @(negedge clk);
    check_value("done_count", done_count, num_entries);
    check_value("noise_taken", noise_taken, num_entries * noise_per_poly);
    check_value("msg_taken", msg_taken, num_entries * msg_per_poly);
    check_value("coef_valid", coef_valid, 0);
    check_value("noise_ready", noise_ready, 1);
    check_value("msg_ready", msg_ready, 1);
    finish_run();
  end

endmodule : tb_kyber_v_noise

`default_nettype wire

// ==== tb.f ====
design/kyber_pkg.sv
design/cbd_sampler.sv
design/noise_fifo.sv
design/message_adder.sv
design/kyber_v_noise.sv
test/kyber_v_noise_sva.sv
test/tb_kyber_v_noise.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the Kyber v-noise testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
sim_exe=tb_kyber_v_noise

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f \
  --top-module tb_kyber_v_noise \
  -Mdir "$build_dir" \
  -o "$sim_exe"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/$sim_exe" +verilator+error+limit+1000 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$log_file"; then
  echo "Simulation result: pass"
  exit 0
fi

echo "Simulation result: fail, see $log_file"
exit 1
